//--- adc_mock.sv
// mock adc, counts the aperture and flags end of measurement
`timescale 1ns/10ps
`default_nettype none

module adc_mock (
  input  wire        clk,
  input  wire        rst_i,
  input  wire        reset_n_i,       // run enable from sequencer
  input  wire [23:0] aperture_i,
  output logic       measure_valid_o
);
  import dmm_pkg::*;

  logic [COUNT_W-1:0] count;
  logic               done;           // holds off until reset_n drops

  always_ff @(posedge clk) begin
    if (rst_i || !reset_n_i) begin
      count           <= '0;
      done            <= 1'b0;
      measure_valid_o <= 1'b0;
    end else begin
      measure_valid_o <= 1'b0;
      if (!done) begin
        if (count == aperture_i) begin
          measure_valid_o <= 1'b1;    // aperture+1 after enable
          done            <= 1'b1;
        end else begin
          count <= count + 1'b1;
        end
      end
    end
  end

endmodule

`default_nettype wire

//--- dmm_pkg.sv
// dmm control package, shared widths, register map, enums and bus structs
`default_nettype none

package dmm_pkg;

  //////////////////////////////
  // widths
  localparam int REG_W     = 32;   // register width
  localparam int ADDR_W    = 7;    // address field of command byte
  localparam int FRAME_W   = 40;   // cmd byte + 32 data bits
  localparam int BIT_CNT_W = 6;    // holds 0..FRAME_W+1
  localparam int SEQ_MAX   = 4;    // sequence slots
  localparam int COUNT_W   = 24;   // clk counters

  localparam logic [7:0] MAGIC_STATUS = 8'hAA;

  //////////////////////////////
  // register map
  localparam logic [7:0] REG_STATUS       = 8'h08;  // read only
  localparam logic [7:0] REG_4094_OE      = 8'h09;
  localparam logic [7:0] REG_MODE         = 8'h0C;
  localparam logic [7:0] REG_DIRECT       = 8'h0D;
  localparam logic [7:0] REG_SA_PRECHARGE = 8'h14;
  localparam logic [7:0] REG_SA_SEQ_N     = 8'h15;
  localparam logic [7:0] REG_SA_SEQ0      = 8'h16;
  localparam logic [7:0] REG_SA_SEQ1      = 8'h17;
  localparam logic [7:0] REG_SA_SEQ2      = 8'h18;
  localparam logic [7:0] REG_SA_SEQ3      = 8'h19;
  localparam logic [7:0] REG_ADC_APERTURE = 8'h1A;

  // spi device select codes
  typedef enum logic [2:0] {
    SPI_CS_DEASSERT   = 3'd0,
    SPI_CS_FPGA0      = 3'd1,   // register set
    SPI_CS_4094       = 3'd2,
    SPI_CS_INVERT_DAC = 3'd3,
    SPI_CS_MDAC1      = 3'd4    // isolated mdac
  } spi_cs_e;

  typedef enum logic [2:0] {
    MODE_DIRECT   = 3'd0,
    MODE_SEQ_MOCK = 3'd6       // sequencer with mocked adc
  } mode_e;

  typedef enum logic [1:0] {SA_IDLE, SA_PRECHARGE, SA_SAMPLE} sa_state_e;

  // one register access from the spi side
  typedef struct packed {
    logic              valid;  // clear for the read strobe
    logic              write;
    logic [ADDR_W-1:0] addr;
    logic [REG_W-1:0]  wdata;
  } reg_access_t;

  typedef struct packed {
    logic [1:0] pc_sw;
    logic [3:0] azmux;
  } seq_entry_t;

  typedef struct packed {
    logic [2:0]                seq_n;
    seq_entry_t [SEQ_MAX-1:0]  seq;
    logic [COUNT_W-1:0]        precharge;
  } sa_params_t;

  // output vector, msb first, 26 bits
  typedef struct packed {
    logic       adc_reset_n;
    logic       meas_complete;
    logic       spi_interrupt;
    logic       cmpr_latch;
    logic       sigmux;
    logic       rstmux;
    logic [1:0] refmux;
    logic [3:0] azmux;
    logic [1:0] pc_sw;
    logic [7:0] monitor;
    logic [3:0] leds;
  } out_vec_t;

endpackage

`default_nettype wire

//--- dmm_top.f
dmm_pkg.sv
spi_frontend.sv
register_set.sv
adc_mock.sv
sequence_acquisition.sv
mode_mux.sv
dmm_top.sv
tb_dmm_top.sv

//--- dmm_top.sv
// dmm control fpga top, spi register access, sequencer and output mux
`timescale 1ns/10ps
`default_nettype none

module dmm_top (
  input  wire        clk,
  input  wire        rst_i,
  input  wire        sck_i,
  input  wire        sdi_i,
  input  wire [2:0]  spi_cs_vec_i,
  input  wire [3:0]  hw_flags_i,
  input  wire        adc_cmpr_i,       // no real adc here, unused
  input  wire        sa_trig_i,
  output wire        sdo_o,
  output wire        spi_glb_clk_o,
  output wire        spi_glb_mosi_o,
  output wire        spi_4094_strobe_o,
  output wire        spi_4094_oe_o,
  output wire        spi_invert_dac_ss_o,
  output wire        spi_iso_cs_o,
  output wire [3:0]  leds_o,
  output wire [7:0]  monitor_o,
  output wire [1:0]  pc_sw_o,
  output wire [3:0]  azmux_o,
  output wire [1:0]  adc_refmux_o,
  output wire        adc_sigmux_o,
  output wire        adc_rstmux_o,
  output wire        adc_cmpr_latch_o,
  output wire        spi_interrupt_o
);
  import dmm_pkg::*;

  reg_access_t access;
  logic [31:0] rdata;
  mode_e       mode;
  out_vec_t    direct_vec, seq_vec, out_vec;
  sa_params_t  sa_params;
  logic [23:0] aperture;
  logic        adc_reset_n, measure_valid;
  logic [2:0]  sample_idx_last;

  spi_frontend u_spi_frontend (
    .clk(clk), .rst_i(rst_i),
    .sck_i(sck_i), .sdi_i(sdi_i), .spi_cs_vec_i(spi_cs_e'(spi_cs_vec_i)),
    .rdata_i(rdata), .sdo_o(sdo_o),
    .spi_glb_clk_o(spi_glb_clk_o), .spi_glb_mosi_o(spi_glb_mosi_o),
    .spi_4094_strobe_o(spi_4094_strobe_o),
    .spi_invert_dac_ss_o(spi_invert_dac_ss_o), .spi_iso_cs_o(spi_iso_cs_o),
    .access_o(access)
  );

  register_set u_register_set (
    .clk(clk), .rst_i(rst_i),
    .access_i(access), .hw_flags_i(hw_flags_i), .sample_idx_last_i(sample_idx_last),
    .rdata_o(rdata), .mode_o(mode), .direct_o(direct_vec),
    .spi_4094_oe_o(spi_4094_oe_o), .sa_params_o(sa_params), .aperture_o(aperture)
  );

  sequence_acquisition u_sequence_acquisition (
    .clk(clk), .rst_i(rst_i), .trig_i(sa_trig_i),
    .params_i(sa_params), .measure_valid_i(measure_valid),
    .adc_reset_n_o(adc_reset_n), .out_o(seq_vec), .sample_idx_last_o(sample_idx_last)
  );

  adc_mock u_adc_mock (
    .clk(clk), .rst_i(rst_i),
    .reset_n_i(adc_reset_n), .aperture_i(aperture), .measure_valid_o(measure_valid)
  );

  mode_mux u_mode_mux (
    .clk(clk), .rst_i(rst_i),
    .mode_i(mode), .direct_i(direct_vec), .seq_i(seq_vec), .out_o(out_vec)
  );

  //////////////////////////////
  // pins, adc_reset_n and meas_complete have no pin
  assign leds_o           = out_vec.leds;
  assign monitor_o        = out_vec.monitor;
  assign pc_sw_o          = out_vec.pc_sw;
  assign azmux_o          = out_vec.azmux;
  assign adc_refmux_o     = out_vec.refmux;
  assign adc_sigmux_o     = out_vec.sigmux;
  assign adc_rstmux_o     = out_vec.rstmux;
  assign adc_cmpr_latch_o = out_vec.cmpr_latch;
  assign spi_interrupt_o  = out_vec.spi_interrupt;

endmodule

`default_nettype wire

//--- mode_mux.sv
// registered mode select of the switch, led and monitor output vector
`timescale 1ns/10ps
`default_nettype none

module mode_mux (
  input  wire               clk,
  input  wire               rst_i,
  input  dmm_pkg::mode_e    mode_i,
  input  dmm_pkg::out_vec_t direct_i,
  input  dmm_pkg::out_vec_t seq_i,
  output dmm_pkg::out_vec_t out_o
);
  import dmm_pkg::*;

  always_ff @(posedge clk) begin
    if (rst_i) begin
      out_o <= '0;                         // all switches open
    end else begin
      case (mode_i)
        MODE_DIRECT:   out_o <= direct_i;  // direct register drives pins
        MODE_SEQ_MOCK: out_o <= seq_i;     // needs trig and seq_n
        default:       out_o <= '0;        // unused slots
      endcase
    end
  end

endmodule

`default_nettype wire

//--- register_set.sv
// control register set with registered read-back and status word
`timescale 1ns/10ps
`default_nettype none

module register_set (
  input  wire                  clk,
  input  wire                  rst_i,
  input  dmm_pkg::reg_access_t access_i,
  input  wire [3:0]            hw_flags_i,
  input  wire [2:0]            sample_idx_last_i,
  output logic [31:0]          rdata_o,
  output dmm_pkg::mode_e       mode_o,
  output dmm_pkg::out_vec_t    direct_o,
  output logic                 spi_4094_oe_o,
  output dmm_pkg::sa_params_t  sa_params_o,
  output logic [23:0]          aperture_o
);
  import dmm_pkg::*;

  logic [2:0]       mode_q;
  logic [REG_W-1:0] status_w;
  logic [REG_W-1:0] rd_word;
  logic [7:0]       addr;      // map constants are 8 bit
  logic             wr_en;

  assign addr  = {1'b0, access_i.addr};
  assign wr_en = access_i.valid & access_i.write;

  assign status_w = {9'b0, sa_params_o.seq_n, 1'b0, sample_idx_last_i,
                     4'b0, hw_flags_i, MAGIC_STATUS};

  //////////////////////////////
  // writes
  always_ff @(posedge clk) begin
    if (rst_i) begin
      mode_q        <= '0;
      direct_o      <= '0;
      spi_4094_oe_o <= 1'b0;       // 4094 outputs off at power up
      sa_params_o   <= '0;
      aperture_o    <= '0;
    end else if (wr_en) begin
      case (addr)
        REG_4094_OE:      spi_4094_oe_o         <= access_i.wdata[0];
        REG_MODE:         mode_q                <= access_i.wdata[2:0];
        REG_DIRECT:       direct_o              <= access_i.wdata[$bits(out_vec_t)-1:0];
        REG_SA_PRECHARGE: sa_params_o.precharge <= access_i.wdata[COUNT_W-1:0];
        REG_SA_SEQ_N:     sa_params_o.seq_n     <= access_i.wdata[2:0];
        REG_SA_SEQ0:      sa_params_o.seq[0]    <= access_i.wdata[5:0];
        REG_SA_SEQ1:      sa_params_o.seq[1]    <= access_i.wdata[5:0];
        REG_SA_SEQ2:      sa_params_o.seq[2]    <= access_i.wdata[5:0];
        REG_SA_SEQ3:      sa_params_o.seq[3]    <= access_i.wdata[5:0];
        REG_ADC_APERTURE: aperture_o            <= access_i.wdata[COUNT_W-1:0];
        default: ;                 // status and unknown, dropped
      endcase
    end
  end

  assign mode_o = mode_e'(mode_q);

  //////////////////////////////
  // read mux, zero extended
  always_comb begin
    case (addr)
      REG_STATUS:       rd_word = status_w;
      REG_4094_OE:      rd_word = {31'b0, spi_4094_oe_o};
      REG_MODE:         rd_word = {29'b0, mode_q};
      REG_DIRECT:       rd_word = {6'b0, direct_o};
      REG_SA_PRECHARGE: rd_word = {8'b0, sa_params_o.precharge};
      REG_SA_SEQ_N:     rd_word = {29'b0, sa_params_o.seq_n};
      REG_SA_SEQ0:      rd_word = {26'b0, sa_params_o.seq[0]};
      REG_SA_SEQ1:      rd_word = {26'b0, sa_params_o.seq[1]};
      REG_SA_SEQ2:      rd_word = {26'b0, sa_params_o.seq[2]};
      REG_SA_SEQ3:      rd_word = {26'b0, sa_params_o.seq[3]};
      REG_ADC_APERTURE: rd_word = {8'b0, aperture_o};
      default:          rd_word = '0;
    endcase
  end

  always_ff @(posedge clk) begin
    if (rst_i) rdata_o <= '0;
    else       rdata_o <= rd_word;   // ready cycle after strobe
  end

endmodule

`default_nettype wire

//--- run_sim.sh
#!/bin/sh
# compile and run the dmm_top testbench with verilator
cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert --timescale 1ns/10ps \
  --top-module tb_dmm_top -Mdir obj_dir -f dmm_top.f
if [ $? -ne 0 ]; then
  echo "verilator build failed"
  exit 1
fi

./obj_dir/Vtb_dmm_top > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if grep -q "TEST RESULT: FAIL" "$LOG"; then
  exit 1
fi
exit 0

//--- sequence_acquisition.sv
// sample acquisition sequencer, precharge then sample for each switch setting
`timescale 1ns/10ps
`default_nettype none

module sequence_acquisition (
  input  wire                 clk,
  input  wire                 rst_i,
  input  wire                 trig_i,            // low holds in reset
  input  dmm_pkg::sa_params_t params_i,
  input  wire                 measure_valid_i,
  output logic                adc_reset_n_o,
  output dmm_pkg::out_vec_t   out_o,
  output logic [2:0]          sample_idx_last_o
);
  import dmm_pkg::*;

  sa_state_e          state;
  logic [2:0]         idx;
  logic [COUNT_W-1:0] cnt;           // precharge clk count
  seq_entry_t         entry;
  logic               hold;

  assign hold  = rst_i | ~trig_i;
  assign entry = params_i.seq[idx[1:0]];

  //////////////////////////////
  // fsm
  always_ff @(posedge clk) begin
    if (hold) begin
      state             <= SA_IDLE;
      idx               <= '0;
      cnt               <= '0;
      sample_idx_last_o <= '0;
    end else if (params_i.seq_n == '0) begin
      state <= SA_IDLE;              // nothing to run
      idx   <= '0;
    end else if (state != SA_IDLE && idx >= params_i.seq_n) begin
      state <= SA_PRECHARGE;         // seq_n shrunk under us, restart
      idx   <= '0;
      cnt   <= '0;
    end else begin
      case (state)
        SA_IDLE: begin
          state <= SA_PRECHARGE;
          idx   <= '0;
          cnt   <= '0;
        end
        SA_PRECHARGE: begin
          if (cnt + 1'b1 >= params_i.precharge)   // zero counts as one
            state <= SA_SAMPLE;
          else
            cnt <= cnt + 1'b1;
        end
        SA_SAMPLE: begin
          if (measure_valid_i) begin
            sample_idx_last_o <= idx;
            idx   <= (idx + 1'b1 >= params_i.seq_n) ? 3'd0 : idx + 1'b1;
            cnt   <= '0;
            state <= SA_PRECHARGE;
          end
        end
        default: state <= SA_IDLE;
      endcase
    end
  end

  //////////////////////////////
  // outputs
  assign adc_reset_n_o = (state == SA_SAMPLE);   // mock adc runs in sample only

  always_comb begin
    out_o = '0;
    if (state != SA_IDLE) begin
      out_o.azmux   = entry.azmux;
      out_o.pc_sw   = (state == SA_SAMPLE) ? entry.pc_sw : 2'b00;
      out_o.leds    = 4'b0001 << idx[1:0];
      out_o.monitor = {2'b00, state, 1'b0, idx};  // state hi, idx lo
    end
  end

  // index stays inside the programmed sequence
  a_idx_range: assert property (@(posedge clk) disable iff (hold)
    (state != SA_IDLE) && $stable(params_i.seq_n) |-> (idx < params_i.seq_n));

  // adc done only expected while sampling
  a_valid_in_sample: assert property (@(posedge clk) disable iff (hold)
    measure_valid_i |-> (state == SA_SAMPLE));

endmodule

`default_nettype wire

//--- spi_frontend.sv
// spi slave port, oversampled in clk, with select decode and register access framing
`timescale 1ns/10ps
`default_nettype none

module spi_frontend (
  input  wire                  clk,
  input  wire                  rst_i,
  input  wire                  sck_i,
  input  wire                  sdi_i,
  input  dmm_pkg::spi_cs_e     spi_cs_vec_i,
  input  wire [31:0]           rdata_i,
  output logic                 sdo_o,
  output logic                 spi_glb_clk_o,
  output logic                 spi_glb_mosi_o,
  output logic                 spi_4094_strobe_o,
  output logic                 spi_invert_dac_ss_o,
  output logic                 spi_iso_cs_o,
  output dmm_pkg::reg_access_t access_o
);
  import dmm_pkg::*;

  logic [2:0]           sck_s;       // 2 sync flops + history
  logic [1:0]           sdi_s;
  logic [1:0][2:0]      cs_s;
  logic                 sel, sel_q;
  logic                 sck_rise, sck_fall;
  logic [BIT_CNT_W-1:0] bit_cnt;
  logic [FRAME_W-1:0]   shift_in;
  logic [REG_W-1:0]     shift_out;
  logic [1:0]           rd_pipe;     // [1] loads read data

  //////////////////////////////
  // device select, raw pins
  assign spi_glb_clk_o       = (spi_cs_vec_i == SPI_CS_FPGA0) ? 1'b1 : sck_i;  // park hi
  assign spi_glb_mosi_o      = (spi_cs_vec_i == SPI_CS_FPGA0) ? 1'b1 : sdi_i;  // park hi
  assign spi_4094_strobe_o   = (spi_cs_vec_i == SPI_CS_4094);        // active hi
  assign spi_invert_dac_ss_o = (spi_cs_vec_i != SPI_CS_INVERT_DAC);  // active lo
  assign spi_iso_cs_o        = (spi_cs_vec_i != SPI_CS_MDAC1);       // active lo

  //////////////////////////////
  // oversampling
  assign sel      = (cs_s[1] == SPI_CS_FPGA0);
  assign sck_rise = sck_s[1] & ~sck_s[2];
  assign sck_fall = ~sck_s[1] & sck_s[2];

  always_ff @(posedge clk) begin
    if (rst_i) begin
      sck_s <= '0;
      sdi_s <= '0;
      cs_s  <= '0;
      sel_q <= 1'b0;
    end else begin
      sck_s <= {sck_s[1:0], sck_i};
      sdi_s <= {sdi_s[0], sdi_i};
      cs_s  <= {cs_s[0], spi_cs_vec_i};
      sel_q <= sel;
    end
  end

  //////////////////////////////
  // framing
  always_ff @(posedge clk) begin
    if (rst_i) begin
      bit_cnt   <= '0;
      shift_in  <= '0;
      shift_out <= '0;
      sdo_o     <= 1'b0;
      rd_pipe   <= '0;
      access_o  <= '0;
    end else begin
      access_o <= '0;                                 // single cycle strobes
      rd_pipe  <= {rd_pipe[0], sel & sck_rise & (bit_cnt == BIT_CNT_W'(7))};
      if (!sel) begin
        bit_cnt   <= '0;
        shift_out <= '0;                              // zeros over cmd byte
        sdo_o     <= 1'b0;
      end else begin
        if (sck_rise) begin
          shift_in <= {shift_in[FRAME_W-2:0], sdi_s[1]};
          if (bit_cnt != BIT_CNT_W'(FRAME_W + 1))     // saturate, long frame
            bit_cnt <= bit_cnt + 1'b1;
          if (bit_cnt == BIT_CNT_W'(7))               // cmd byte done, read strobe
            access_o.addr <= {shift_in[ADDR_W-2:0], sdi_s[1]};
        end
        if (rd_pipe[1]) begin
          shift_out <= rdata_i;                       // rdata registered one cycle after strobe
        end else if (sck_fall) begin
          sdo_o     <= shift_out[REG_W-1];
          shift_out <= {shift_out[REG_W-2:0], 1'b0};
        end
      end
      // end of frame, exact length only
      if (sel_q && !sel && bit_cnt == BIT_CNT_W'(FRAME_W)) begin
        access_o.valid <= 1'b1;
        access_o.write <= shift_in[FRAME_W-1];
        access_o.addr  <= shift_in[FRAME_W-2 -: ADDR_W];
        access_o.wdata <= shift_in[REG_W-1:0];
      end
    end
  end

  // one access per frame
  a_single_valid: assert property (@(posedge clk) disable iff (rst_i)
    access_o.valid |=> !access_o.valid);

endmodule

`default_nettype wire

//--- tb_dmm_top.sv
// testbench for the dmm control top covering spi register access, select decode and sequencer
`timescale 1ns/10ps
`default_nettype none

module tb_dmm_top;
  import dmm_pkg::*;

  localparam int HALF_SCK    = 8;                       // clk cycles per sck phase
  localparam int SETTLE      = 10;                      // cs release to outputs
  localparam int NUM_STIM    = 28;
  localparam int TIMEOUT_CYC = NUM_STIM * 400 + 20000;
  localparam int PHASE_LIMIT = 500;                     // longest sequencer phase wait

  typedef struct packed {
    spi_cs_e     cs;
    logic        wr;
    logic [7:0]  addr;
    logic [31:0] data;
    logic [31:0] exp;
    logic        chk;                                   // compare read data
  } stim_t;

  logic       clk = 1'b0;
  logic       rst;
  logic       sck, sdi, adc_cmpr, sa_trig;
  logic [2:0] cs_vec;
  logic [3:0] hw_flags;
  wire        sdo, glb_clk, glb_mosi, strobe_4094, oe_4094, inv_dac_ss, iso_cs;
  wire  [3:0] leds, azmux;
  wire  [7:0] monitor;
  wire  [1:0] pc_sw, refmux;
  wire        sigmux, rstmux, cmpr_latch, spi_int;

  integer seed    = 32'h0079_8c9b;
  int     err_cnt = 0;
  int     chk_cnt = 0;
  int     cycles  = 0;
  int     n_stim  = 0;
  logic   oe_exp;                                       // 4094 oe bit written by the table
  stim_t  stim [NUM_STIM];

  dmm_top dut_i (
    .clk(clk), .rst_i(rst), .sck_i(sck), .sdi_i(sdi), .spi_cs_vec_i(cs_vec),
    .hw_flags_i(hw_flags), .adc_cmpr_i(adc_cmpr), .sa_trig_i(sa_trig),
    .sdo_o(sdo), .spi_glb_clk_o(glb_clk), .spi_glb_mosi_o(glb_mosi),
    .spi_4094_strobe_o(strobe_4094), .spi_4094_oe_o(oe_4094),
    .spi_invert_dac_ss_o(inv_dac_ss), .spi_iso_cs_o(iso_cs),
    .leds_o(leds), .monitor_o(monitor), .pc_sw_o(pc_sw), .azmux_o(azmux),
    .adc_refmux_o(refmux), .adc_sigmux_o(sigmux), .adc_rstmux_o(rstmux),
    .adc_cmpr_latch_o(cmpr_latch), .spi_interrupt_o(spi_int)
  );

  always #10 clk = ~clk;                                // 20 ns period

  //////////////////////////////
  // compare helpers
  task automatic check_bit(input string name, input logic act, input logic exp);
    chk_cnt++;
    if (act !== exp) begin
      err_cnt++;
      $display("FAIL t=%0t %s got %b expected %b", $time, name, act, exp);
    end
  endtask

  task automatic check_word(input string name, input logic [31:0] act, input logic [31:0] exp);
    chk_cnt++;
    if (act !== exp) begin
      err_cnt++;
      $display("FAIL t=%0t %s got %h expected %h", $time, name, act, exp);
    end
  endtask

  task automatic check_vec(input string name, input out_vec_t act, input out_vec_t exp);
    chk_cnt++;
    if (act !== exp) begin
      err_cnt++;
      $display("FAIL t=%0t %s got %h expected %h", $time, name, act, exp);
    end
  endtask

  function automatic logic [31:0] rand32();
    return $random(seed);
  endfunction

  // output pins gathered back into the vector layout
  function automatic out_vec_t pins_vec();
    out_vec_t v;
    v               = '0;                               // adc_reset_n, meas_complete have no pin
    v.spi_interrupt = spi_int;
    v.cmpr_latch    = cmpr_latch;
    v.sigmux        = sigmux;
    v.rstmux        = rstmux;
    v.refmux        = refmux;
    v.azmux         = azmux;
    v.pc_sw         = pc_sw;
    v.monitor       = monitor;
    v.leds          = leds;
    return v;
  endfunction

  // implemented bits per register
  function automatic logic [31:0] width_mask(input logic [7:0] addr);
    case (addr)
      REG_4094_OE:                       return 32'h0000_0001;
      REG_MODE, REG_SA_SEQ_N:            return 32'h0000_0007;
      REG_DIRECT:                        return 32'h03FF_FFFF;
      REG_SA_PRECHARGE, REG_ADC_APERTURE: return 32'h00FF_FFFF;
      REG_SA_SEQ0, REG_SA_SEQ1,
      REG_SA_SEQ2, REG_SA_SEQ3:          return 32'h0000_003F;
      default:                           return 32'h0;
    endcase
  endfunction

  function automatic logic [31:0] status_word(input logic [2:0] seqn, input logic [2:0] idx);
    return 32'(MAGIC_STATUS) | (32'(hw_flags) << 8) | (32'(idx) << 16) | (32'(seqn) << 20);
  endfunction

  // select decode and shared line parking
  task automatic check_parking(input spi_cs_e cs);
    logic own;
    own = (cs == SPI_CS_FPGA0);
    check_bit("spi_glb_clk_o", glb_clk, own ? 1'b1 : sck);
    check_bit("spi_glb_mosi_o", glb_mosi, own ? 1'b1 : sdi);
    check_bit("spi_4094_strobe_o", strobe_4094, cs == SPI_CS_4094);
    check_bit("spi_invert_dac_ss_o", inv_dac_ss, cs != SPI_CS_INVERT_DAC);
    check_bit("spi_iso_cs_o", iso_cs, cs != SPI_CS_MDAC1);
  endtask

  //////////////////////////////
  // spi master in mode 0 sending msb first
  task automatic spi_frame(input spi_cs_e cs, input logic wr, input logic [7:0] addr,
                           input logic [31:0] data, output logic [31:0] rd);
    logic [39:0] frame;
    int          i;
    frame = {wr, addr[6:0], data};
    rd    = '0;
    @(negedge clk);
    cs_vec = cs;
    repeat (HALF_SCK) @(negedge clk);                   // select through the synchronizer
    for (i = 39; i >= 0; i--) begin
      sdi = frame[i];
      repeat (HALF_SCK) @(negedge clk);
      check_parking(cs);
      if (i >= 32)
        check_bit("sdo_o", sdo, 1'b0);                  // zeros over the command byte
      else
        rd = {rd[30:0], sdo};
      sck = 1'b1;
      repeat (HALF_SCK) @(negedge clk);
      check_parking(cs);
      sck = 1'b0;
    end
    repeat (HALF_SCK) @(negedge clk);
    cs_vec = SPI_CS_DEASSERT;                           // frame ends here
    repeat (SETTLE) @(negedge clk);
  endtask

  task automatic add_entry(input spi_cs_e cs, input logic wr, input logic [7:0] addr,
                           input logic [31:0] data, input logic [31:0] exp, input logic chk);
    stim[n_stim].cs   = cs;
    stim[n_stim].wr   = wr;
    stim[n_stim].addr = addr;
    stim[n_stim].data = data;
    stim[n_stim].exp  = exp;
    stim[n_stim].chk  = chk;
    n_stim++;
  endtask

  task automatic build_table();
    logic [7:0]  wr_addr [10];
    logic [31:0] shadow [10];
    logic [31:0] d;
    int          k;
    wr_addr = '{REG_4094_OE, REG_MODE, REG_DIRECT, REG_SA_PRECHARGE, REG_SA_SEQ_N,
                REG_SA_SEQ0, REG_SA_SEQ1, REG_SA_SEQ2, REG_SA_SEQ3, REG_ADC_APERTURE};
    for (k = 0; k < 10; k++) begin
      d         = rand32();
      shadow[k] = d & width_mask(wr_addr[k]);
      add_entry(SPI_CS_FPGA0, 1'b1, wr_addr[k], d, '0, 1'b0);
    end
    oe_exp = shadow[0][0];
    for (k = 0; k < 10; k++)
      add_entry(SPI_CS_FPGA0, 1'b0, wr_addr[k], rand32(), shadow[k], 1'b1);
    add_entry(SPI_CS_FPGA0, 1'b1, REG_STATUS, rand32(), '0, 1'b0);   // read only
    add_entry(SPI_CS_FPGA0, 1'b0, REG_STATUS, '0, status_word(shadow[4][2:0], 3'd0), 1'b1);
    add_entry(SPI_CS_FPGA0, 1'b0, 8'h30, '0, '0, 1'b1);             // unmapped
    // writes to other devices leave mode untouched
    add_entry(SPI_CS_DEASSERT, 1'b1, REG_MODE, ~shadow[1], '0, 1'b0);
    add_entry(SPI_CS_4094, 1'b1, REG_MODE, ~shadow[1], '0, 1'b0);
    add_entry(SPI_CS_INVERT_DAC, 1'b1, REG_MODE, ~shadow[1], '0, 1'b0);
    add_entry(SPI_CS_MDAC1, 1'b1, REG_MODE, ~shadow[1], '0, 1'b0);
    add_entry(SPI_CS_FPGA0, 1'b0, REG_MODE, '0, shadow[1], 1'b1);
  endtask

  //////////////////////////////
  // direct and undefined modes
  task automatic run_direct();
    logic [31:0] rd, d;
    logic [2:0]  m;
    out_vec_t    exp_vec;
    spi_frame(SPI_CS_FPGA0, 1'b1, REG_MODE, 32'(MODE_DIRECT), rd);
    d = rand32();
    spi_frame(SPI_CS_FPGA0, 1'b1, REG_DIRECT, d, rd);
    exp_vec               = d[25:0];
    exp_vec.adc_reset_n   = 1'b0;                       // not on a pin
    exp_vec.meas_complete = 1'b0;
    check_vec("direct outputs", pins_vec(), exp_vec);
    d = rand32();
    m = d[2:0];
    if (m == 3'(MODE_DIRECT) || m == 3'(MODE_SEQ_MOCK))
      m = 3'd7;                                         // force an unused slot
    spi_frame(SPI_CS_FPGA0, 1'b1, REG_MODE, {29'b0, m}, rd);
    check_vec("undefined mode outputs", pins_vec(), '0);
  endtask

  task automatic wait_phase(input sa_state_e st, input int k, output logic ok);
    int n;
    n = 0;
    while (!(monitor[7:4] == 4'(st) && monitor[3:0] == 4'(k)) && n < PHASE_LIMIT) begin
      @(negedge clk);
      n++;
    end
    ok = (n < PHASE_LIMIT);
    if (!ok) begin
      err_cnt++;
      $display("sequencer never reached %s of entry %0d by t=%0t", st.name(), k, $time);
    end
  endtask

  //////////////////////////////
  // sequencer over three entries
  task automatic run_sequencer();
    seq_entry_t  ent [3];
    out_vec_t    exp_vec;
    logic [31:0] rd, d;
    logic        ok;
    int          v, k;
    d = 32'd3 + (rand32() & 32'hF);                     // short precharge
    spi_frame(SPI_CS_FPGA0, 1'b1, REG_SA_PRECHARGE, d, rd);
    d = 32'd5 + (rand32() & 32'h1F);                    // short aperture
    spi_frame(SPI_CS_FPGA0, 1'b1, REG_ADC_APERTURE, d, rd);
    for (k = 0; k < 3; k++) begin
      d      = rand32();
      ent[k] = d[5:0];
      spi_frame(SPI_CS_FPGA0, 1'b1, REG_SA_SEQ0 + 8'(k), d, rd);
    end
    spi_frame(SPI_CS_FPGA0, 1'b1, REG_SA_SEQ_N, 32'd3, rd);
    spi_frame(SPI_CS_FPGA0, 1'b1, REG_MODE, 32'(MODE_SEQ_MOCK), rd);
    sa_trig = 1'b1;                                     // releases the sequencer
    for (v = 0; v < 6; v++) begin
      k = v % 3;
      wait_phase(SA_PRECHARGE, k, ok);
      if (!ok)
        break;
      exp_vec         = '0;
      exp_vec.azmux   = ent[k].azmux;
      exp_vec.leds    = 4'b0001 << k;
      exp_vec.monitor = {4'(SA_PRECHARGE), 4'(k)};
      check_vec("precharge outputs", pins_vec(), exp_vec);
      wait_phase(SA_SAMPLE, k, ok);
      if (!ok)
        break;
      exp_vec.pc_sw   = ent[k].pc_sw;                   // switch closes in sample
      exp_vec.monitor = {4'(SA_SAMPLE), 4'(k)};
      check_vec("sample outputs", pins_vec(), exp_vec);
    end
    spi_frame(SPI_CS_FPGA0, 1'b0, REG_STATUS, '0, rd);
    check_word("status while running", rd & ~32'h0007_0000, status_word(3'd3, 3'd0));
    chk_cnt++;
    if (rd[18:16] >= 3'd3) begin
      err_cnt++;
      $display("FAIL t=%0t sample_idx_last got %0d expected below 3", $time, rd[18:16]);
    end
    sa_trig = 1'b0;
  endtask

  //////////////////////////////
  // main flow
  initial begin : main
    logic [31:0] rd;
    int          n;
    rst      = 1'b1;
    sck      = 1'b0;
    sdi      = 1'b0;
    cs_vec   = SPI_CS_DEASSERT;
    adc_cmpr = 1'b0;
    sa_trig  = 1'b0;
    rd       = rand32();
    hw_flags = rd[3:0];
    repeat (8) @(negedge clk);                          // 8 reset cycles
    rst = 1'b0;
    @(negedge clk);
    check_vec("reset outputs", pins_vec(), '0);
    check_bit("spi_4094_oe_o", oe_4094, 1'b0);
    check_bit("spi_invert_dac_ss_o", inv_dac_ss, 1'b1);
    check_bit("spi_iso_cs_o", iso_cs, 1'b1);
    check_bit("sdo_o", sdo, 1'b0);
    build_table();
    for (n = 0; n < n_stim; n++) begin
      spi_frame(stim[n].cs, stim[n].wr, stim[n].addr, stim[n].data, rd);
      if (stim[n].chk)
        check_word($sformatf("rdata addr %02h", stim[n].addr), rd, stim[n].exp);
    end
    check_bit("spi_4094_oe_o", oe_4094, oe_exp);
    spi_frame(SPI_CS_FPGA0, 1'b1, REG_4094_OE, {31'b0, ~oe_exp}, rd);
    check_bit("spi_4094_oe_o", oe_4094, ~oe_exp);       // pin follows both levels
    run_direct();
    run_sequencer();
    $display("checks: %0d  errors: %0d", chk_cnt, err_cnt);
    if (err_cnt == 0)
      $display("TEST RESULT: PASS");
    else
      $display("TEST RESULT: FAIL");
    $finish;
  end

  // run length guard
  initial begin : watchdog
    while (cycles < TIMEOUT_CYC) begin
      @(posedge clk);
      cycles++;
    end
    $display("timeout, the test did not finish within %0d cycles", cycles);
    $display("checks: %0d  errors: %0d", chk_cnt, err_cnt);
    $display("TEST RESULT: FAIL");
    $finish;
  end

endmodule

`default_nettype wire
